// ==== sources.f ====
+incdir+common
common/tile_mem_pkg.sv
src/bram_infer.sv
wb2sram/wb2sram.sv
src/wb_sram_sp.sv
verification/tb_wb_sram_sp.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the tile memory testbench with verilator
# exit status is non zero when the log holds the fail line

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing \
   --top-module tb_wb_sram_sp \
   -f sources.f \
   -o tb_sim \
   > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -q "Testbench failed" sim.log && { echo "simulation reported errors"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation clean"

// ==== verification/tb_wb_sram_sp.sv ====
// ----------------------------------------
// testbench for the wishbone tile memory
// shadow copy follows every accepted write
// bytes never written are not compared
// a lost response is closed after 2 cycles
// ----------------------------------------

`timescale 1ns/10ps

`include "tile_mem_defs.svh"

module tb_wb_sram_sp;

   import tile_mem_pkg::*;

   localparam int       lsb        = $clog2(`TILE_MEM_DW / 8);
   localparam int       words      = 2 ** `TILE_MEM_AW;
   localparam bus_adr_t mem_bytes  = bus_adr_t'(`TILE_MEM_SIZE);
   localparam int       rst_cyc    = 16;
   localparam int       n_acc      = 376; // bus accesses over all tests
   localparam int       timeout_ns = (n_acc * 4 + rst_cyc + 200) * 40;

   logic     clk;
   logic     rst_n;
   logic     cyc;
   logic     stb;
   logic     we;
   bus_adr_t adr;
   sel_t     sel;
   word_t    wdat;
   logic     ack;
   logic     err;
   word_t    rdat;

   word_t shadow [words]; // expected ram contents
   sel_t  known  [words]; // lanes written so far

   // expectation posted by the bus task
   logic     exp_we;
   logic     exp_err;
   bus_adr_t exp_adr;
   word_t    exp_dat;
   word_t    exp_mask;
   int       exp_cyc   = 0;
   int       post_cnt  = 0; // accesses started
   int       resp_cnt  = 0; // accesses answered by the compare process
   int       cyc_cnt   = 0; // negedges seen
   int       err_cnt   = 0;
   int       chk_cnt   = 0;
   int       test_base = 0;
   int       n_tests   = 0;

   wb_sram_sp dut (
      .clk_i    (clk),
      .rst_n_i  (rst_n),
      .wb_cyc_i (cyc),
      .wb_stb_i (stb),
      .wb_we_i  (we),
      .wb_adr_i (adr),
      .wb_sel_i (sel),
      .wb_dat_i (wdat),
      .wb_ack_o (ack),
      .wb_err_o (err),
      .wb_dat_o (rdat)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk; // 40 ns period
   end

   // each selected lane takes the new byte
   function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input sel_t s);
      word_t m;
      m = old_w;
      for (int l = 0; l < $bits(sel_t); l++) begin
         if (s[l]) begin
            m[8*l +: 8] = new_w[8*l +: 8];
         end
      end
      return m;
   endfunction

   // 0xff on every lane that holds a known byte
   function automatic word_t lane_mask(input sel_t k);
      word_t m;
      m = '0;
      for (int l = 0; l < $bits(sel_t); l++) begin
         if (k[l]) begin
            m[8*l +: 8] = 8'hff;
         end
      end
      return m;
   endfunction

   // expected read word with the low address bits dropped
   function automatic word_t exp_read(input bus_adr_t a);
      return shadow[a[lsb +: `TILE_MEM_AW]];
   endfunction

   // prefill pattern from the whole address
   function automatic word_t fill_word(input bus_adr_t a);
      return {a[31:16] ^ a[15:0], ~a[15:0]};
   endfunction

   // one classic cycle
   // cyc and stb stay up for a back to back call
   task automatic bus_access(input logic w, input bus_adr_t a, input sel_t s, input word_t d);
      word_adr_t wi;
      logic      oor;
      wi  = a[lsb +: `TILE_MEM_AW];
      oor = (a >= mem_bytes); // no write may land
      @(posedge clk);
      cyc  <= 1'b1;
      stb  <= 1'b1;
      we   <= w;
      adr  <= a;
      sel  <= s;
      wdat <= d;
      exp_we   = w;
      exp_err  = oor;
      exp_adr  = a;
      exp_dat  = exp_read(a);
      exp_mask = lane_mask(known[wi]);
      exp_cyc  = cyc_cnt;
      if (w && !oor) begin
         shadow[wi] = merge_bytes(shadow[wi], d, s);
         known[wi]  = known[wi] | s;
      end
      post_cnt++;
      wait (resp_cnt == post_cnt); // set at the negedge of the ack cycle
   endtask

   // cyc low with a stray stb that must be ignored
   task automatic bus_idle(input int n);
      repeat (n) begin
         @(posedge clk);
         cyc <= 1'b0;
         stb <= 1'($urandom);
      end
   endtask

   task automatic end_test(input int num, input string name);
      int n;
      n = err_cnt - test_base;
      if (n == 0) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         $display("test %0d %s: %0d errors", num, name, n);
      end
      test_base = err_cnt;
      n_tests++;
   endtask

   // compare at mid cycle where outputs have settled
   always @(negedge clk) begin
      int lat;
      cyc_cnt = cyc_cnt + 1;
      lat     = cyc_cnt - exp_cyc; // 2 in the ack cycle
      if (ack && err) begin
         $display("** Error: wb_ack_o = %h and wb_err_o = %h together", ack, err);
         err_cnt++;
      end
      if (post_cnt == resp_cnt) begin
         if (ack || err) begin
            $display("response at cycle %0d while no access was pending", cyc_cnt);
            err_cnt++;
         end
      end else if (ack || err) begin
         chk_cnt++;
         if (lat != 2) begin
            $display("response %0d cycles after the strobe at adr %h", lat - 1, exp_adr);
            err_cnt++;
         end
         if (err !== exp_err) begin
            $display("** Error: wb_err_o = %h, expected %h (adr %h)", err, exp_err, exp_adr);
            err_cnt++;
         end
         if (ack !== !exp_err) begin
            $display("** Error: wb_ack_o = %h, expected %h (adr %h)", ack, !exp_err, exp_adr);
            err_cnt++;
         end
         if (ack && !exp_we && ((rdat & exp_mask) !== (exp_dat & exp_mask))) begin
            $display("** Error: wb_dat_o = %h, expected %h (mask %h, adr %h)",
                     rdat, exp_dat, exp_mask, exp_adr);
            err_cnt++;
         end
         resp_cnt++;
      end else if (lat >= 2) begin
         $display("no ack or err for the access at adr %h", exp_adr);
         err_cnt++;
         resp_cnt++; // release the bus task
      end
   end

   initial begin
      #(timeout_ns);
      $display("watchdog stopped the run after %0d ns", timeout_ns);
      $display("Testbench failed");
      $finish;
   end

   initial begin
      int unsigned seed;
      int          gap;
      int          r;
      bus_adr_t    a;
      sel_t        lane_sel [8];
      seed = $urandom(32'h3d36_3fdf);
      lane_sel = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h5, 4'ha, 4'h3, 4'hc};
      for (int i = 0; i < words; i++) begin
         shadow[i] = '0;
         known[i]  = '0;
      end
      rst_n <= 1'b0;
      cyc   <= 1'b0;
      stb   <= 1'b0;
      we    <= 1'b0;
      adr   <= '0;
      sel   <= '0;
      wdat  <= '0;

      // no response may appear during reset and idle
      repeat (rst_cyc) @(posedge clk);
      rst_n <= 1'b1;
      repeat (8) @(posedge clk);
      end_test(1, "reset and idle");

      for (int i = 0; i < 10; i++) begin
         bus_access(1'b1, bus_adr_t'(i * 400 + 1), 4'hf, word_t'($urandom)); // odd low bits
         bus_idle(1);
      end
      for (int i = 0; i < 10; i++) begin
         bus_access(1'b0, bus_adr_t'(i * 400), 4'hf, '0);
         bus_idle(1);
      end
      end_test(2, "full word write and read");

      for (int i = 0; i < 8; i++) begin
         a = bus_adr_t'(32'h800 + 4 * i);
         bus_access(1'b1, a, 4'hf, fill_word(a));
         bus_idle(1);
      end
      for (int i = 0; i < 8; i++) begin
         bus_access(1'b1, bus_adr_t'(32'h800 + 4 * i), lane_sel[i], word_t'(32'h1234_5670 + i));
         bus_idle(1);
      end
      for (int i = 0; i < 8; i++) begin
         bus_access(1'b0, bus_adr_t'(32'h800 + 4 * i), 4'hf, '0);
         bus_idle(1);
      end
      end_test(3, "byte lane merge");

      // same word index as test 3 which must stay untouched
      for (int i = 0; i < 4; i++) begin
         a = mem_bytes * bus_adr_t'(i + 1) + bus_adr_t'(32'h800 + 4 * i);
         bus_access(1'b1, a, 4'hf, 32'hdead_beef);
         bus_access(1'b0, a, 4'hf, '0);
         bus_access(1'b0, bus_adr_t'(32'h800 + 4 * i), 4'hf, '0);
         bus_idle(1);
      end
      // boundary at the first byte past the ram and the last byte inside it
      bus_access(1'b1, mem_bytes, 4'hf, 32'hdead_beef);
      bus_access(1'b0, bus_adr_t'(0), 4'hf, '0); // word 0 holds data from test 2
      bus_access(1'b1, mem_bytes - 1, 4'hf, 32'h0bad_cafe);
      bus_access(1'b0, mem_bytes - 4, 4'hf, '0);
      bus_idle(1);
      end_test(4, "out of range");

      repeat (300) begin
         r = $urandom % 8;
         if (r == 0) begin
            a = mem_bytes | bus_adr_t'($urandom); // out of range
         end else if (r == 1) begin
            a = bus_adr_t'($urandom) % mem_bytes;
         end else begin
            a = bus_adr_t'($urandom) % 256; // small window so reads hit known words
         end
         bus_access(1'($urandom), a, sel_t'($urandom), word_t'($urandom));
         gap = $urandom % 3;
         if (gap > 0) begin
            bus_idle(gap);
         end
      end
      bus_idle(1);
      end_test(5, "random traffic");

      for (int i = 0; i < 8; i++) begin
         a = bus_adr_t'(32'hc00 + 4 * i);
         bus_access(1'b1, a, 4'hf, word_t'($urandom));
         bus_access(1'b0, a, 4'hf, '0); // no gap
      end
      bus_idle(2);
      end_test(6, "back to back");

      $display("tests %0d, checks %0d, errors %0d", n_tests, chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== src/wb_sram_sp.sv ====
// ----------------------------------------
// local tile memory with wishbone port
// classic cycles only, two cycle latency
// err on any address at or above the size
// ----------------------------------------

`timescale 1ns/10ps

module wb_sram_sp (
   input  logic                   clk_i,
   input  logic                   rst_n_i,

   // wishbone classic slave
   input  logic                   wb_cyc_i,
   input  logic                   wb_stb_i,
   input  logic                   wb_we_i,
   input  tile_mem_pkg::bus_adr_t wb_adr_i,
   input  tile_mem_pkg::sel_t     wb_sel_i,
   input  tile_mem_pkg::word_t    wb_dat_i,
   output logic                   wb_ack_o,
   output logic                   wb_err_o,
   output tile_mem_pkg::word_t    wb_dat_o
);

   import tile_mem_pkg::*;

   // adapter to ram wires
   word_adr_t mem_adr;
   sel_t      mem_we_sel; // per lane write strobe
   word_t     mem_wdat;
   word_t     mem_rdat;   // one cycle after the address

   // bus decode and response
   wb2sram u_wb2sram (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .wb_cyc_i     (wb_cyc_i),
      .wb_stb_i     (wb_stb_i),
      .wb_we_i      (wb_we_i),
      .wb_adr_i     (wb_adr_i),
      .wb_sel_i     (wb_sel_i),
      .wb_dat_i     (wb_dat_i),
      .wb_ack_o     (wb_ack_o),
      .wb_err_o     (wb_err_o),
      .wb_dat_o     (wb_dat_o),
      .mem_adr_o    (mem_adr),
      .mem_we_sel_o (mem_we_sel),
      .mem_wdat_o   (mem_wdat),
      .mem_rdat_i   (mem_rdat)
   );

   // storage
   // no reset port on the ram
   bram_infer u_bram (
      .clk_i    (clk_i),
      .adr_i    (mem_adr),
      .we_sel_i (mem_we_sel),
      .dat_i    (mem_wdat),
      .dat_o    (mem_rdat)
   );

endmodule

// ==== wb2sram/wb2sram.sv ====
// ----------------------------------------
// wishbone classic slave to byte lane ram
// one access in flight, no bursts
// ack or err exactly one cycle after stb
// address bits below the word are ignored
// out of range access never writes
// wb_dat_o is only valid together with ack
// ----------------------------------------

`timescale 1ns/10ps

`include "tile_mem_defs.svh"

module wb2sram (
   input  logic                   clk_i,
   input  logic                   rst_n_i,

   // wishbone slave side
   input  logic                   wb_cyc_i,
   input  logic                   wb_stb_i,
   input  logic                   wb_we_i,
   input  tile_mem_pkg::bus_adr_t wb_adr_i,
   input  tile_mem_pkg::sel_t     wb_sel_i,
   input  tile_mem_pkg::word_t    wb_dat_i,
   output logic                   wb_ack_o,
   output logic                   wb_err_o,
   output tile_mem_pkg::word_t    wb_dat_o,

   // ram side
   output tile_mem_pkg::word_adr_t mem_adr_o,
   output tile_mem_pkg::sel_t      mem_we_sel_o,  // we already folded in
   output tile_mem_pkg::word_t     mem_wdat_o,
   input  tile_mem_pkg::word_t     mem_rdat_i
);

   import tile_mem_pkg::*;

   // byte offset bits inside one word
   localparam int adr_lsb = $clog2(`TILE_MEM_DW / 8);

   // first byte address past the ram
   localparam bus_adr_t mem_bytes = bus_adr_t'(`TILE_MEM_SIZE);

   wb_state_t state_q;
   wb_state_t state_d;

   logic req;      // new request this cycle
   logic in_range; // byte address inside the ram
   logic wr_ok;    // in range write accepted now
   logic ack_q;
   logic err_q;

   // input side

   // only look at the bus in IDLE
   // the RESP cycle still sees the old request held by the master
   assign req = wb_cyc_i & wb_stb_i & (state_q == IDLE);

   assign in_range = (wb_adr_i < mem_bytes);

   assign wr_ok = req & wb_we_i & in_range;

   // word index straight from the bus
   assign mem_adr_o = wb_adr_i[adr_lsb +: `TILE_MEM_AW];

   // lane strobes only for a fresh in range write
   assign mem_we_sel_o = wb_sel_i & {$bits(sel_t){wr_ok}};

   assign mem_wdat_o = wb_dat_i; // lanes not selected are masked by the strobes

   // fsm

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (req) begin
               state_d = RESP; // answer next cycle
            end
         end
         RESP: begin
            state_d = IDLE; // back for a back to back request
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   // output side

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
         ack_q   <= 1'b0;
         err_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         ack_q   <= req & in_range;  // good access
         err_q   <= req & ~in_range; // outside the ram
      end
   end

   assign wb_ack_o = ack_q;
   assign wb_err_o = err_q;

   // ram output is already one cycle late
   // so it lines up with ack without another register
   assign wb_dat_o = mem_rdat_i;

endmodule

// ==== src/bram_infer.sv ====
// ----------------------------------------
// inferred single port byte lane ram
// registered read address
// write first on the same word
// no reset and no preload
// contents undefined after power up
// ----------------------------------------

`timescale 1ns/10ps

`include "tile_mem_defs.svh"

module bram_infer (
   input  logic                    clk_i,
   input  tile_mem_pkg::word_adr_t adr_i,
   input  tile_mem_pkg::sel_t      we_sel_i, // one write enable per byte
   input  tile_mem_pkg::word_t     dat_i,
   output tile_mem_pkg::word_t     dat_o
);

   import tile_mem_pkg::*;

   // entries per lane array
   localparam int depth = 2 ** `TILE_MEM_AW;

   // byte lanes in one word
   localparam int lanes = $bits(sel_t);

   word_adr_t adr_q; // captured read address

   // read address register shared by all lanes
   always_ff @(posedge clk_i) begin
      adr_q <= adr_i;
   end

   // one byte wide array per lane
   for (genvar l = 0; l < lanes; l++) begin : g_lane

      logic [7:0] mem [depth];

      // lane writes only under its own select bit
      always_ff @(posedge clk_i) begin
         if (we_sel_i[l]) begin
            mem[adr_i] <= dat_i[8*l +: 8];
         end
      end

      // read after the edge
      // a write to the captured word shows up here at once
      assign dat_o[8*l +: 8] = mem[adr_q];

   end

endmodule

// ==== common/tile_mem_pkg.sv ====
// ----------------------------------------
// shared types of the tile memory
// widths follow tile_mem_defs.svh
// ----------------------------------------

package tile_mem_pkg;

`include "tile_mem_defs.svh"

   // one data word on the bus and in the ram
   typedef logic [`TILE_MEM_DW-1:0] word_t;

   // byte lane select, one bit per byte
   typedef logic [(`TILE_MEM_DW/8)-1:0] sel_t;

   // wishbone byte address
   typedef logic [31:0] bus_adr_t;

   // word index into the ram arrays
   typedef logic [`TILE_MEM_AW-1:0] word_adr_t;

   // adapter fsm
   typedef enum logic {
      IDLE, // waiting for cyc and stb
      RESP  // ack or err on the bus this cycle
   } wb_state_t;

endpackage

// ==== common/tile_mem_defs.svh ====
// ----------------------------------------
// sizing of the local tile memory
// TILE_MEM_SIZE must be a power of two
// and below 2**32 bytes
// data path is fixed at one 32 bit word
// ----------------------------------------

`ifndef TILE_MEM_DEFS_SVH
`define TILE_MEM_DEFS_SVH

// one bus word
`define TILE_MEM_DW 32

// memory size in bytes
`define TILE_MEM_SIZE 4096

// word index width
// log2 of the size in words (10 at 4 kB)
`define TILE_MEM_AW ($clog2(`TILE_MEM_SIZE / (`TILE_MEM_DW / 8)))

`endif
